// File: design/flash_boot_pkg.sv
`default_nettype none

package flash_boot_pkg;

  localparam int unsigned addr_w       = 40;
  localparam int unsigned data_w       = 64;
  localparam int unsigned spi_word_w   = 32;
  localparam int unsigned flash_addr_w = 20;

  // SSPI controller block on the ring
  localparam logic [addr_w-1:0] spi_base = 40'h00_0010_0000;

  localparam logic [addr_w-1:0] ctrl_addr      = spi_base + 40'h00;
  localparam logic [addr_w-1:0] ssi_en_addr    = spi_base + 40'h08;
  localparam logic [addr_w-1:0] ser_addr       = spi_base + 40'h10;
  localparam logic [addr_w-1:0] baudr_addr     = spi_base + 40'h14;
  localparam logic [addr_w-1:0] tx_ftlr_addr   = spi_base + 40'h18;
  localparam logic [addr_w-1:0] rx_ftlr_addr   = spi_base + 40'h1c;
  localparam logic [addr_w-1:0] stat_addr      = spi_base + 40'h28;
  // tx and rx fifo share one window
  localparam logic [addr_w-1:0] fifo_addr      = spi_base + 40'h60;
  localparam logic [addr_w-1:0] spi_ctrl0_addr = spi_base + 40'hf4;

  localparam logic [data_w-1:0] disable_val        = 64'h0;
  localparam logic [data_w-1:0] dft_32_val         = 64'h0000_0000_001f_0000;
  localparam logic [data_w-1:0] baudr_val          = 64'h2;
  localparam logic [data_w-1:0] fifo_threshold_val = 64'h4;
  localparam logic [data_w-1:0] ser_val            = 64'h1;
  localparam logic [data_w-1:0] spi_ctrl0_val      = 64'h0000_0000_0000_021a;
  localparam logic [data_w-1:0] enable_val         = 64'h1;

  localparam int unsigned init_depth = 8;

  // status register bits
  localparam int unsigned stat_tx_not_full  = 1;
  localparam int unsigned stat_rx_not_empty = 3;

  localparam int unsigned frame_words = 3;

  typedef enum logic [7:0] {
    flash_page_program = 8'h02,
    flash_read         = 8'h03
  } flash_op_e;

  typedef enum logic [3:0] {
    boot_reset,
    init_write,
    init_wait,
    idle,
    tx_poll,
    tx_stat_wait,
    tx_write,
    rx_poll,
    rx_stat_wait,
    rx_get,
    rx_data_wait
  } boot_state_e;

endpackage

`default_nettype wire

// File: design/spi_init_rom.sv
`default_nettype none

module spi_init_rom (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              init_next,
  output logic [flash_boot_pkg::addr_w-1:0] init_addr,
  output logic [flash_boot_pkg::data_w-1:0] init_data,
  output logic                              init_last
);

  logic [3:0] step;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      step <= '0;
    end else if (init_next && !init_last) begin
      step <= step + 4'd1;
    end
  end

  assign init_last = (step == 4'(flash_boot_pkg::init_depth));

  // disable, configure, select slave, enable
  always_comb begin
    init_addr = '0;
    init_data = '0;
    case (step)
      4'd0: begin
        init_addr = flash_boot_pkg::ssi_en_addr;
        init_data = flash_boot_pkg::disable_val;
      end
      4'd1: begin
        init_addr = flash_boot_pkg::ctrl_addr;
        init_data = flash_boot_pkg::dft_32_val;
      end
      4'd2: begin
        init_addr = flash_boot_pkg::baudr_addr;
        init_data = flash_boot_pkg::baudr_val;
      end
      4'd3: begin
        init_addr = flash_boot_pkg::tx_ftlr_addr;
        init_data = flash_boot_pkg::fifo_threshold_val;
      end
      4'd4: begin
        init_addr = flash_boot_pkg::rx_ftlr_addr;
        init_data = flash_boot_pkg::fifo_threshold_val;
      end
      4'd5: begin
        init_addr = flash_boot_pkg::ser_addr;
        init_data = flash_boot_pkg::ser_val;
      end
      4'd6: begin
        init_addr = flash_boot_pkg::spi_ctrl0_addr;
        init_data = flash_boot_pkg::spi_ctrl0_val;
      end
      4'd7: begin
        init_addr = flash_boot_pkg::ssi_en_addr;
        init_data = flash_boot_pkg::enable_val;
      end
      default: begin
        init_addr = '0;
        init_data = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/flash_cmd_queue.sv
`default_nettype none

module flash_cmd_queue (
  input  logic                                  clk,
  input  logic                                  rstn,
  input  logic                                  accept_en,
  input  logic                                  s_aw_valid,
  input  logic                                  s_ar_valid,
  input  logic                                  s_b_ready,
  input  logic [flash_boot_pkg::addr_w-1:0]     s_aw_addr,
  input  logic [flash_boot_pkg::addr_w-1:0]     s_ar_addr,
  input  logic [flash_boot_pkg::data_w-1:0]     s_w_data,
  output logic                                  s_aw_ready,
  output logic                                  s_ar_ready,
  output logic                                  s_b_valid,
  input  logic                                  word_take,
  output logic                                  word_valid,
  output logic [flash_boot_pkg::spi_word_w-1:0] word_data,
  output logic                                  read_pending,
  input  logic                                  frame_done
);

  logic [flash_boot_pkg::spi_word_w-1:0] frame_q [flash_boot_pkg::frame_words];
  logic [1:0]                            words_left;
  logic                                  can_accept;
  logic                                  ar_fire;
  logic                                  aw_fire;
  logic [flash_boot_pkg::spi_word_w-1:0] cmd_word;

  assign can_accept = accept_en && (words_left == 2'd0);

  // reads win over writes
  assign s_ar_ready = can_accept;
  assign s_aw_ready = can_accept && !s_ar_valid && s_b_ready;
  assign ar_fire    = s_ar_valid && s_ar_ready;
  assign aw_fire    = s_aw_valid && s_aw_ready;
  assign s_b_valid  = aw_fire;

  always_comb begin
    if (s_ar_valid) begin
      cmd_word = {flash_boot_pkg::flash_read, 4'h0,
                  s_ar_addr[flash_boot_pkg::flash_addr_w-1:0]};
    end else begin
      cmd_word = {flash_boot_pkg::flash_page_program, 4'h0,
                  s_aw_addr[flash_boot_pkg::flash_addr_w-1:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      words_left <= 2'd0;
    end else if (ar_fire || aw_fire) begin
      words_left <= 2'(flash_boot_pkg::frame_words);
    end else if (word_take && word_valid) begin
      words_left <= words_left - 2'd1;
    end
  end

  // frame words shift toward slot 0
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      frame_q[0] <= cmd_word;
      frame_q[1] <= '0;
      frame_q[2] <= '0;
    end else if (aw_fire) begin
      frame_q[0] <= cmd_word;
      frame_q[1] <= s_w_data[63:32];
      frame_q[2] <= s_w_data[31:0];
    end else if (word_take && word_valid) begin
      frame_q[0] <= frame_q[1];
      frame_q[1] <= frame_q[2];
      frame_q[2] <= '0;
    end
  end

  assign word_valid = (words_left != 2'd0);
  assign word_data  = frame_q[0];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      read_pending <= 1'b0;
    end else if (ar_fire) begin
      read_pending <= 1'b1;
    end else if (frame_done) begin
      read_pending <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: design/flash_read_assembler.sv
`default_nettype none

module flash_read_assembler (
  input  logic                                  clk,
  input  logic                                  rstn,
  input  logic                                  rx_word_valid,
  input  logic [flash_boot_pkg::spi_word_w-1:0] rx_word,
  output logic                                  rx_ready,
  output logic                                  s_r_valid,
  input  logic                                  s_r_ready,
  output logic [flash_boot_pkg::data_w-1:0]     s_r_data
);

  logic                                  upper_done;
  logic [flash_boot_pkg::spi_word_w-1:0] swapped;

  // first flash byte arrives in bits 7:0, goes to the top
  assign swapped = {rx_word[7:0], rx_word[15:8], rx_word[23:16], rx_word[31:24]};

  assign rx_ready = !s_r_valid;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      upper_done <= 1'b0;
      s_r_valid  <= 1'b0;
    end else begin
      if (rx_word_valid && rx_ready) begin
        upper_done <= !upper_done;
        if (upper_done) begin
          s_r_valid <= 1'b1;
        end
      end else if (s_r_valid && s_r_ready) begin
        s_r_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_word_valid && rx_ready) begin
      if (upper_done) begin
        s_r_data[31:0] <= swapped;
      end else begin
        s_r_data[63:32] <= swapped;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/boot_bus_ctrl.sv
`default_nettype none

module boot_bus_ctrl (
  input  logic                                  clk,
  input  logic                                  rstn,
  input  logic                                  boot_ena,
  input  logic [flash_boot_pkg::addr_w-1:0]     init_addr,
  input  logic [flash_boot_pkg::data_w-1:0]     init_data,
  input  logic                                  init_last,
  output logic                                  init_next,
  input  logic                                  word_valid,
  input  logic [flash_boot_pkg::spi_word_w-1:0] word_data,
  input  logic                                  read_pending,
  output logic                                  word_take,
  output logic                                  accept_en,
  output logic                                  frame_done,
  input  logic                                  rx_ready,
  output logic                                  rx_word_valid,
  output logic [flash_boot_pkg::spi_word_w-1:0] rx_word,
  output logic                                  m_aw_valid,
  output logic [flash_boot_pkg::addr_w-1:0]     m_aw_addr,
  output logic [flash_boot_pkg::data_w-1:0]     m_w_data,
  input  logic                                  m_aw_ready,
  input  logic                                  m_b_valid,
  output logic                                  m_ar_valid,
  output logic [flash_boot_pkg::addr_w-1:0]     m_ar_addr,
  input  logic                                  m_ar_ready,
  input  logic                                  m_r_valid,
  input  logic [flash_boot_pkg::data_w-1:0]     m_r_data,
  output logic                                  m_r_ready
);

  flash_boot_pkg::boot_state_e state, state_nxt;
  logic [1:0] word_cnt;
  logic       last_word;
  logic       r_fire;

  assign last_word = (word_cnt == 2'(flash_boot_pkg::frame_words - 1));
  assign r_fire    = m_r_valid && m_r_ready;

  always_ff @(posedge clk) begin
    if (!rstn || !boot_ena) begin
      state <= flash_boot_pkg::boot_reset;
    end else begin
      state <= state_nxt;
    end
  end

  // shared word count, tx words then rx words
  always_ff @(posedge clk) begin
    if (!rstn || !boot_ena) begin
      word_cnt <= 2'd0;
    end else if ((state == flash_boot_pkg::tx_write && m_aw_ready) ||
                 (state == flash_boot_pkg::rx_data_wait && r_fire)) begin
      word_cnt <= last_word ? 2'd0 : word_cnt + 2'd1;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      flash_boot_pkg::boot_reset: state_nxt = flash_boot_pkg::init_write;
      flash_boot_pkg::init_write: begin
        if (init_last) begin
          state_nxt = flash_boot_pkg::idle;
        end else if (m_aw_ready) begin
          state_nxt = flash_boot_pkg::init_wait;
        end
      end
      flash_boot_pkg::init_wait: begin
        if (m_b_valid) begin
          state_nxt = flash_boot_pkg::init_write;
        end
      end
      flash_boot_pkg::idle: begin
        if (word_valid) begin
          state_nxt = flash_boot_pkg::tx_poll;
        end
      end
      flash_boot_pkg::tx_poll: begin
        if (m_ar_ready) begin
          state_nxt = flash_boot_pkg::tx_stat_wait;
        end
      end
      flash_boot_pkg::tx_stat_wait: begin
        if (m_r_valid) begin
          state_nxt = m_r_data[flash_boot_pkg::stat_tx_not_full] ?
                      flash_boot_pkg::tx_write : flash_boot_pkg::tx_poll;
        end
      end
      flash_boot_pkg::tx_write: begin
        if (m_aw_ready) begin
          if (!last_word) begin
            state_nxt = flash_boot_pkg::tx_poll;
          end else begin
            state_nxt = read_pending ? flash_boot_pkg::rx_poll : flash_boot_pkg::idle;
          end
        end
      end
      flash_boot_pkg::rx_poll: begin
        if (m_ar_ready) begin
          state_nxt = flash_boot_pkg::rx_stat_wait;
        end
      end
      flash_boot_pkg::rx_stat_wait: begin
        if (m_r_valid) begin
          state_nxt = m_r_data[flash_boot_pkg::stat_rx_not_empty] ?
                      flash_boot_pkg::rx_get : flash_boot_pkg::rx_poll;
        end
      end
      flash_boot_pkg::rx_get: begin
        if (m_ar_ready) begin
          state_nxt = flash_boot_pkg::rx_data_wait;
        end
      end
      flash_boot_pkg::rx_data_wait: begin
        if (r_fire) begin
          state_nxt = last_word ? flash_boot_pkg::idle : flash_boot_pkg::rx_poll;
        end
      end
      default: state_nxt = flash_boot_pkg::boot_reset;
    endcase
  end

  assign init_next  = (state == flash_boot_pkg::init_wait) && m_b_valid;
  assign word_take  = (state == flash_boot_pkg::tx_write) && m_aw_ready;
  // hold off new requests while an answer is still parked
  assign accept_en  = (state == flash_boot_pkg::idle) && rx_ready;
  assign frame_done = (state_nxt == flash_boot_pkg::idle) &&
                      (state == flash_boot_pkg::tx_write ||
                       state == flash_boot_pkg::rx_data_wait);

  assign m_aw_valid = (state == flash_boot_pkg::init_write && !init_last) ||
                      (state == flash_boot_pkg::tx_write);
  assign m_aw_addr  = (state == flash_boot_pkg::init_write) ? init_addr :
                      flash_boot_pkg::fifo_addr;
  assign m_w_data   = (state == flash_boot_pkg::init_write) ? init_data :
                      {32'h0, word_data};

  assign m_ar_valid = (state == flash_boot_pkg::tx_poll) ||
                      (state == flash_boot_pkg::rx_poll) ||
                      (state == flash_boot_pkg::rx_get);
  assign m_ar_addr  = (state == flash_boot_pkg::rx_get) ? flash_boot_pkg::fifo_addr :
                      flash_boot_pkg::stat_addr;

  // word 0 is the command echo, dropped without waiting on the assembler
  assign m_r_ready  = (state == flash_boot_pkg::tx_stat_wait) ||
                      (state == flash_boot_pkg::rx_stat_wait) ||
                      (state == flash_boot_pkg::rx_data_wait &&
                       (word_cnt == 2'd0 || rx_ready));

  assign rx_word_valid = (state == flash_boot_pkg::rx_data_wait) && r_fire &&
                         (word_cnt != 2'd0);
  assign rx_word       = m_r_data[flash_boot_pkg::spi_word_w-1:0];

endmodule

`default_nettype wire

// File: design/flash_boot_bridge.sv
`default_nettype none

module flash_boot_bridge (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              boot_ena,
  input  logic                              s_aw_valid,
  input  logic [flash_boot_pkg::addr_w-1:0] s_aw_addr,
  input  logic [flash_boot_pkg::data_w-1:0] s_w_data,
  output logic                              s_aw_ready,
  output logic                              s_b_valid,
  input  logic                              s_b_ready,
  input  logic                              s_ar_valid,
  input  logic [flash_boot_pkg::addr_w-1:0] s_ar_addr,
  output logic                              s_ar_ready,
  output logic                              s_r_valid,
  output logic [flash_boot_pkg::data_w-1:0] s_r_data,
  input  logic                              s_r_ready,
  output logic                              m_aw_valid,
  output logic [flash_boot_pkg::addr_w-1:0] m_aw_addr,
  output logic [flash_boot_pkg::data_w-1:0] m_w_data,
  input  logic                              m_aw_ready,
  input  logic                              m_b_valid,
  output logic                              m_ar_valid,
  output logic [flash_boot_pkg::addr_w-1:0] m_ar_addr,
  input  logic                              m_ar_ready,
  input  logic                              m_r_valid,
  input  logic [flash_boot_pkg::data_w-1:0] m_r_data,
  output logic                              m_r_ready
);

  logic [flash_boot_pkg::addr_w-1:0]     init_addr;
  logic [flash_boot_pkg::data_w-1:0]     init_data;
  logic                                  init_last;
  logic                                  init_next;
  logic                                  accept_en;
  logic                                  word_valid;
  logic [flash_boot_pkg::spi_word_w-1:0] word_data;
  logic                                  word_take;
  logic                                  read_pending;
  logic                                  frame_done;
  logic                                  rx_ready;
  logic                                  rx_word_valid;
  logic [flash_boot_pkg::spi_word_w-1:0] rx_word;

  spi_init_rom u_init_rom (
    .clk       (clk),
    .rstn      (rstn),
    .init_next (init_next),
    .init_addr (init_addr),
    .init_data (init_data),
    .init_last (init_last)
  );

  flash_cmd_queue u_cmd_queue (
    .clk          (clk),
    .rstn         (rstn),
    .accept_en    (accept_en),
    .s_aw_valid   (s_aw_valid),
    .s_ar_valid   (s_ar_valid),
    .s_b_ready    (s_b_ready),
    .s_aw_addr    (s_aw_addr),
    .s_ar_addr    (s_ar_addr),
    .s_w_data     (s_w_data),
    .s_aw_ready   (s_aw_ready),
    .s_ar_ready   (s_ar_ready),
    .s_b_valid    (s_b_valid),
    .word_take    (word_take),
    .word_valid   (word_valid),
    .word_data    (word_data),
    .read_pending (read_pending),
    .frame_done   (frame_done)
  );

  flash_read_assembler u_read_asm (
    .clk           (clk),
    .rstn          (rstn),
    .rx_word_valid (rx_word_valid),
    .rx_word       (rx_word),
    .rx_ready      (rx_ready),
    .s_r_valid     (s_r_valid),
    .s_r_ready     (s_r_ready),
    .s_r_data      (s_r_data)
  );

  boot_bus_ctrl u_bus_ctrl (
    .clk           (clk),
    .rstn          (rstn),
    .boot_ena      (boot_ena),
    .init_addr     (init_addr),
    .init_data     (init_data),
    .init_last     (init_last),
    .init_next     (init_next),
    .word_valid    (word_valid),
    .word_data     (word_data),
    .read_pending  (read_pending),
    .word_take     (word_take),
    .accept_en     (accept_en),
    .frame_done    (frame_done),
    .rx_ready      (rx_ready),
    .rx_word_valid (rx_word_valid),
    .rx_word       (rx_word),
    .m_aw_valid    (m_aw_valid),
    .m_aw_addr     (m_aw_addr),
    .m_w_data      (m_w_data),
    .m_aw_ready    (m_aw_ready),
    .m_b_valid     (m_b_valid),
    .m_ar_valid    (m_ar_valid),
    .m_ar_addr     (m_ar_addr),
    .m_ar_ready    (m_ar_ready),
    .m_r_valid     (m_r_valid),
    .m_r_data      (m_r_data),
    .m_r_ready     (m_r_ready)
  );

endmodule

`default_nettype wire

// File: test/sspi_flash_model.sv
`default_nettype none

module sspi_flash_model (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              m_aw_valid,
  input  logic [flash_boot_pkg::addr_w-1:0] m_aw_addr,
  input  logic [flash_boot_pkg::data_w-1:0] m_w_data,
  output logic                              m_aw_ready,
  output logic                              m_b_valid,
  input  logic                              m_ar_valid,
  input  logic [flash_boot_pkg::addr_w-1:0] m_ar_addr,
  output logic                              m_ar_ready,
  output logic                              m_r_valid,
  output logic [flash_boot_pkg::data_w-1:0] m_r_data,
  input  logic                              m_r_ready
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned log_depth = 64;
  localparam int unsigned mem_bytes = 2 ** flash_boot_pkg::flash_addr_w;

  logic [7:0]                              mem [mem_bytes];
  logic [flash_boot_pkg::addr_w-1:0]       wr_addr_log [log_depth];
  logic [flash_boot_pkg::data_w-1:0]       wr_data_log [log_depth];
  int unsigned                             wr_count;
  int unsigned                             rd_count;
  logic [flash_boot_pkg::spi_word_w-1:0]   rx_fifo [$];
  int unsigned                             rx_delay;
  logic [1:0]                              frame_idx;
  logic                                    frame_is_read;
  logic [flash_boot_pkg::flash_addr_w-1:0] frame_addr;
  logic [flash_boot_pkg::spi_word_w-1:0]   data_hi;
  logic [flash_boot_pkg::spi_word_w-1:0]   fifo_word;
  logic [flash_boot_pkg::data_w-1:0]       stat;

  // fill pattern over all address bits
  initial begin
    for (int i = 0; i < mem_bytes; i++) begin
      mem[i] <= 8'(i) ^ 8'(i >> 8) ^ 8'(i >> 16);
    end
  end

  // four flash bytes as one rx word, first byte in bits 7:0
  function automatic logic [31:0] rx_bytes(input logic [19:0] a);
    return {mem[a + 20'd3], mem[a + 20'd2], mem[a + 20'd1], mem[a]};
  endfunction

  always @(posedge clk) begin
    if (!rstn) begin
      m_aw_ready <= 1'b0;
      m_b_valid  <= 1'b0;
      m_ar_ready <= 1'b0;
      m_r_valid  <= 1'b0;
      m_r_data   <= '0;
      wr_count   <= 0;
      rd_count   <= 0;
      rx_delay   <= 0;
      frame_idx  <= 2'd0;
      rx_fifo.delete();
    end else begin
      m_aw_ready <= ($urandom % 4) != 0;
      m_ar_ready <= ($urandom % 4) != 0;
      m_b_valid  <= m_aw_valid && m_aw_ready;
      if (rx_delay != 0) begin
        rx_delay <= rx_delay - 1;
      end
      if (m_aw_valid && m_aw_ready) begin
        if (wr_count < log_depth) begin
          wr_addr_log[wr_count] <= m_aw_addr;
          wr_data_log[wr_count] <= m_w_data;
        end
        wr_count <= wr_count + 1;
        if (m_aw_addr == flash_boot_pkg::fifo_addr) begin
          fifo_word = m_w_data[31:0];
          case (frame_idx)
            2'd0: begin
              frame_is_read = (fifo_word[31:24] == flash_boot_pkg::flash_read);
              frame_addr    = fifo_word[19:0];
              if (frame_is_read) begin
                rx_fifo.push_back('0);
              end
            end
            2'd1: begin
              data_hi = fifo_word;
              if (frame_is_read) begin
                rx_fifo.push_back(rx_bytes(frame_addr));
              end
            end
            default: begin
              if (frame_is_read) begin
                rx_fifo.push_back(rx_bytes(frame_addr + 20'd4));
              end else begin
                // msb first, data high word leads
                for (int k = 0; k < 8; k++) begin
                  mem[frame_addr + 20'(k)] <= 8'({data_hi, fifo_word} >> (56 - 8 * k));
                end
              end
            end
          endcase
          // rx words only for read frames
          if (frame_is_read) begin
            rx_delay <= 1 + $urandom % 4;
          end
          frame_idx <= (frame_idx == 2'd2) ? 2'd0 : frame_idx + 2'd1;
        end
      end
      if (m_r_valid && m_r_ready) begin
        m_r_valid <= 1'b0;
      end
      if (m_ar_valid && m_ar_ready) begin
        rd_count  <= rd_count + 1;
        m_r_valid <= 1'b1;
        if (m_ar_addr == flash_boot_pkg::fifo_addr && rx_fifo.size() != 0) begin
          m_r_data <= {32'h0, rx_fifo.pop_front()};
        end else if (m_ar_addr == flash_boot_pkg::stat_addr) begin
          stat = '0;
          stat[flash_boot_pkg::stat_tx_not_full]  = 1'b1;
          stat[flash_boot_pkg::stat_rx_not_empty] = (rx_fifo.size() != 0) && (rx_delay == 0);
          m_r_data <= stat;
        end else begin
          m_r_data <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: test/flash_boot_properties.sv
`default_nettype none

module flash_boot_properties (
  input logic                              clk,
  input logic                              rstn,
  input logic                              boot_ena,
  input logic                              m_aw_valid,
  input logic                              m_aw_ready,
  input logic [flash_boot_pkg::addr_w-1:0] m_aw_addr,
  input logic [flash_boot_pkg::data_w-1:0] m_w_data,
  input logic                              m_ar_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  // write request holds with stable payload until taken
  aw_hold: assert property (@(posedge clk) disable iff (!rstn || !boot_ena)
    (m_aw_valid && !m_aw_ready) |=>
      (m_aw_valid && $stable(m_aw_addr) && $stable(m_w_data)))
    else $error("m_aw_valid dropped or changed before m_aw_ready");

  aw_ar_exclusive: assert property (@(posedge clk) disable iff (!rstn)
    !(m_aw_valid && m_ar_valid))
    else $error("m_aw_valid and m_ar_valid high together");

  quiet_without_boot: assert property (@(posedge clk) disable iff (!rstn)
    !boot_ena |-> (!m_aw_valid && !m_ar_valid))
    else $error("master request raised while boot_ena is low");

endmodule

bind boot_bus_ctrl flash_boot_properties u_props (
  .clk        (clk),
  .rstn       (rstn),
  .boot_ena   (boot_ena),
  .m_aw_valid (m_aw_valid),
  .m_aw_ready (m_aw_ready),
  .m_aw_addr  (m_aw_addr),
  .m_w_data   (m_w_data),
  .m_ar_valid (m_ar_valid)
);

`default_nettype wire

// File: test/flash_boot_tb.sv
`default_nettype none

module flash_boot_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned op_count        = 8;
  localparam int unsigned watchdog_cycles = op_count * 400;

  typedef struct packed {
    logic                              is_read;
    logic [flash_boot_pkg::addr_w-1:0] addr;
    logic [flash_boot_pkg::data_w-1:0] data;
    logic [flash_boot_pkg::data_w-1:0] expected;
  } op_t;

  // kind, address, data, expected
  localparam op_t op_table [op_count] = '{
    '{1'b0, 40'h00_0000_0100, 64'h0123_4567_89ab_cdef, 64'h0123_4567_89ab_cdef},
    '{1'b1, 40'h00_0000_0100, 64'h0,                   64'h0123_4567_89ab_cdef},
    '{1'b0, 40'h00_0002_a08,  64'hdead_beef_cafe_f00d, 64'hdead_beef_cafe_f00d},
    '{1'b0, 40'h00_0007_fff0, 64'h1122_3344_5566_7788, 64'h1122_3344_5566_7788},
    '{1'b1, 40'h00_0002_a08,  64'h0,                   64'hdead_beef_cafe_f00d},
    '{1'b1, 40'h00_0007_fff0, 64'h0,                   64'h1122_3344_5566_7788},
    '{1'b0, 40'h00_0000_0100, 64'ha5a5_5a5a_0f0f_f0f0, 64'ha5a5_5a5a_0f0f_f0f0},
    '{1'b1, 40'h00_0000_0100, 64'h0,                   64'ha5a5_5a5a_0f0f_f0f0}
  };

  localparam logic [flash_boot_pkg::addr_w-1:0] init_addr_exp [flash_boot_pkg::init_depth] = '{
    flash_boot_pkg::ssi_en_addr, flash_boot_pkg::ctrl_addr, flash_boot_pkg::baudr_addr,
    flash_boot_pkg::tx_ftlr_addr, flash_boot_pkg::rx_ftlr_addr, flash_boot_pkg::ser_addr,
    flash_boot_pkg::spi_ctrl0_addr, flash_boot_pkg::ssi_en_addr
  };
  localparam logic [flash_boot_pkg::data_w-1:0] init_data_exp [flash_boot_pkg::init_depth] = '{
    flash_boot_pkg::disable_val, flash_boot_pkg::dft_32_val, flash_boot_pkg::baudr_val,
    flash_boot_pkg::fifo_threshold_val, flash_boot_pkg::fifo_threshold_val,
    flash_boot_pkg::ser_val, flash_boot_pkg::spi_ctrl0_val, flash_boot_pkg::enable_val
  };

  logic                              clk;
  logic                              rstn;
  logic                              boot_ena;
  logic                              s_aw_valid;
  logic [flash_boot_pkg::addr_w-1:0] s_aw_addr;
  logic [flash_boot_pkg::data_w-1:0] s_w_data;
  logic                              s_aw_ready;
  logic                              s_b_valid;
  logic                              s_b_ready;
  logic                              s_ar_valid;
  logic [flash_boot_pkg::addr_w-1:0] s_ar_addr;
  logic                              s_ar_ready;
  logic                              s_r_valid;
  logic [flash_boot_pkg::data_w-1:0] s_r_data;
  logic                              s_r_ready;
  logic                              m_aw_valid;
  logic [flash_boot_pkg::addr_w-1:0] m_aw_addr;
  logic [flash_boot_pkg::data_w-1:0] m_w_data;
  logic                              m_aw_ready;
  logic                              m_b_valid;
  logic                              m_ar_valid;
  logic [flash_boot_pkg::addr_w-1:0] m_ar_addr;
  logic                              m_ar_ready;
  logic                              m_r_valid;
  logic [flash_boot_pkg::data_w-1:0] m_r_data;
  logic                              m_r_ready;

  flash_boot_bridge DUT (.*);

  sspi_flash_model flash_model (
    .clk        (clk),
    .rstn       (rstn),
    .m_aw_valid (m_aw_valid),
    .m_aw_addr  (m_aw_addr),
    .m_w_data   (m_w_data),
    .m_aw_ready (m_aw_ready),
    .m_b_valid  (m_b_valid),
    .m_ar_valid (m_ar_valid),
    .m_ar_addr  (m_ar_addr),
    .m_ar_ready (m_ar_ready),
    .m_r_valid  (m_r_valid),
    .m_r_data   (m_r_data),
    .m_r_ready  (m_r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_addr(input string name, input logic [flash_boot_pkg::addr_w-1:0] got,
                            input logic [flash_boot_pkg::addr_w-1:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_data(input string name, input logic [flash_boot_pkg::data_w-1:0] got,
                            input logic [flash_boot_pkg::data_w-1:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int unsigned got, input int unsigned exp);
    if (got != exp) begin
      stop_with_failure($sformatf("error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  // eight flash bytes with the lowest address in the top byte
  function automatic logic [63:0] flash_bytes(input logic [19:0] a);
    logic [63:0] v;
    v = '0;
    for (int k = 0; k < 8; k++) begin
      v = {v[55:0], flash_model.mem[a + 20'(k)]};
    end
    return v;
  endfunction

  // bridge idle with no frame or answer in flight
  task automatic wait_idle();
    do @(posedge clk); while (s_ar_ready !== 1'b1);
  endtask

  task automatic run_write(input op_t op);
    s_aw_valid <= 1'b1;
    s_aw_addr  <= op.addr;
    s_w_data   <= op.data;
    do @(posedge clk); while (s_aw_ready !== 1'b1);
    check_flag("s_b_valid", s_b_valid, 1'b1);
    s_aw_valid <= 1'b0;
    wait_idle();
    check_data("flash array", flash_bytes(op.addr[flash_boot_pkg::flash_addr_w-1:0]),
               op.expected);
  endtask

  task automatic run_read(input op_t op);
    logic done;
    done = 1'b0;
    s_ar_valid <= 1'b1;
    s_ar_addr  <= op.addr;
    do @(posedge clk); while (s_ar_ready !== 1'b1);
    s_ar_valid <= 1'b0;
    while (!done) begin
      @(posedge clk);
      if (s_r_valid === 1'b1) begin
        check_data("s_r_data", s_r_data, op.expected);
        done = s_r_ready;
      end
      s_r_ready <= 1'($urandom % 2);
    end
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    stop_with_failure("watchdog expired before all operations completed");
  end

  initial begin
    void'($urandom(32'hcf29_1146));
    rstn       = 1'b0;
    boot_ena   = 1'b0;
    s_aw_valid = 1'b0;
    s_aw_addr  = '0;
    s_w_data   = '0;
    s_b_ready  = 1'b1;
    s_ar_valid = 1'b0;
    s_ar_addr  = '0;
    s_r_ready  = 1'b0;
    repeat (2) @(posedge clk);
    rstn <= 1'b1;

    // boot held off
    repeat (10) @(posedge clk);
    check_count("master writes before boot", flash_model.wr_count, 0);
    check_count("master reads before boot", flash_model.rd_count, 0);

    boot_ena <= 1'b1;
    wait_idle();
    check_count("setup write count", flash_model.wr_count, flash_boot_pkg::init_depth);
    for (int i = 0; i < flash_boot_pkg::init_depth; i++) begin
      check_addr("setup write address", flash_model.wr_addr_log[i], init_addr_exp[i]);
      check_data("setup write data", flash_model.wr_data_log[i], init_data_exp[i]);
    end

    for (int i = 0; i < op_count; i++) begin
      if (op_table[i].is_read) begin
        run_read(op_table[i]);
      end else begin
        run_write(op_table[i]);
      end
    end
    wait_idle();
    check_count("total master writes", flash_model.wr_count,
                flash_boot_pkg::init_depth + flash_boot_pkg::frame_words * op_count);

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
design/flash_boot_pkg.sv
design/spi_init_rom.sv
design/flash_cmd_queue.sv
design/flash_read_assembler.sv
design/boot_bus_ctrl.sv
design/flash_boot_bridge.sv
test/sspi_flash_model.sv
test/flash_boot_properties.sv
test/flash_boot_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --timing --assert --top-module flash_boot_tb -f project.f \
  -o flash_boot_sim && ./obj_dir/flash_boot_sim 2>&1)
echo "$out"
echo "$out" | grep -q "Finished with no errors" && exit 0 || exit 1
